//--- test/rv_uncore_vectors.txt
# op a b c d (hex). csr w s c: a=index b=data. r: a=index b=expected data c=expected illegal
# F L: a=addr b=expected data c=sel. S: a=addr b=data c=sel. P: fetch addr, load addr, their data. i: a=pulses
# mscratch read-modify-write
w 340 a5a5a5a5 0 0
r 340 a5a5a5a5 0 0
s 340 0000ff00 0 0
r 340 a5a5ffa5 0 0
c 340 a5000005 0 0
r 340 00a5ffa0 0 0
# unknown index
w 7c0 ffffffff 0 0
r 7c0 00000000 1 0
r 340 00a5ffa0 0 0
# all counters frozen
w 320 ffffffff 0 0
r 320 0000007d 0 0
w b00 12345678 0 0
w b80 9abcdef0 0 0
w b02 00000010 0 0
w b83 00000001 0 0
r b00 12345678 0 0
r b80 9abcdef0 0 0
r b02 00000010 0 0
r b83 00000001 0 0
w b83 00000000 0 0
# minstret runs again
c 320 00000004 0 0
i 5 0 0 0
r b02 00000015 0 0
r 320 00000079 0 0
# hpm3 loads, hpm4 stores, hpm5 fetches, hpm6 instret
w 323 00000002 0 0
w 324 00000003 0 0
w 325 00000001 0 0
w 326 00000005 0 0
r 324 00000003 0 0
c 320 00000078 0 0
r 320 00000001 0 0
# bus traffic, memory starts as the inverted address
F 100 fffffeff 0 0
F 104 fffffefb 0 0
F 3f0 fffffc0f 0 0
L 200 fffffdff f 0
S 200 11223344 3 0
S 204 aabbccdd c 0
S 208 55667788 5 0
S 20c 01020304 f 0
L 200 ffff3344 f 0
L 204 aabbfdfb f 0
L 208 ff66fd88 f 0
L 20c 01020304 f 0
P 108 300 fffffef7 fffffcff
P 10c 204 fffffef3 aabbfdfb
i 3 0 0 0
# event counts
r b03 00000007 0 0
r b04 00000004 0 0
r b05 00000005 0 0
r b06 00000003 0 0
r b83 00000000 0 0
r b02 00000018 0 0
r b00 12345678 0 0

//--- vlog.f
common/rv_pkg.sv
common/rv_csr_if.sv
common/rv_bus_ev_if.sv
source/rv_wb_arbiter.sv
csr/rv_hpm_event_sel.sv
csr/rv_hpm_counter.sv
csr/rv_csr_file.sv
source/rv_uncore_wb.sv
test/rv_uncore_assert.sv
test/tb_rv_uncore_wb.sv

//--- Bender.yml
package:
  name: rv_uncore_wb

sources:
  - files:
      - common/rv_pkg.sv
      - common/rv_csr_if.sv
      - common/rv_bus_ev_if.sv
      - source/rv_wb_arbiter.sv
      - csr/rv_hpm_event_sel.sv
      - csr/rv_hpm_counter.sv
      - csr/rv_csr_file.sv
      - source/rv_uncore_wb.sv
  - target: test
    files:
      - test/rv_uncore_assert.sv
      - test/tb_rv_uncore_wb.sv

//--- test/tb_rv_uncore_wb.sv
`default_nettype none

module tb_rv_uncore_wb;

    import rv_pkg::*;

    localparam int ACK_TIMEOUT = 32;                    // cycles per bus wait.

    logic        i_clk;
    logic        i_rst;
    logic        i_instr_req;
    addr_t       i_instr_addr;
    logic        o_instr_ack;
    word_t       o_instr_data;
    logic        i_data_req;
    logic        i_data_write;
    addr_t       i_data_addr;
    word_t       i_data_wdata;
    sel_t        i_data_sel;
    logic        o_data_ack;
    word_t       o_data_rdata;
    csr_idx_t    i_csr_idx;
    word_t       i_csr_wdata;
    logic        i_csr_write;
    logic        i_csr_set;
    logic        i_csr_clear;
    logic        i_csr_read;
    word_t       o_csr_rdata;
    logic        o_csr_valid;
    logic        o_csr_illegal;
    logic        i_instret;
    addr_t       o_wb_adr;
    word_t       o_wb_dat;
    word_t       i_wb_dat;
    logic        o_wb_we;
    sel_t        o_wb_sel;
    logic        o_wb_stb;
    logic        o_wb_cyc;
    logic        i_wb_ack;

    word_t       mem [256];
    logic [15:0] lfsr_q;
    logic [1:0]  wait_left;
    logic        busy;
    logic        s_rst;
    logic        s_cyc;
    logic        s_stb;
    logic        s_we;
    addr_t       s_adr;
    word_t       s_dat;
    sel_t        s_sel;

    int          fd;
    int          nfields;
    string       line;
    byte         op;
    word_t       f_a;
    word_t       f_b;
    word_t       f_c;
    word_t       f_d;

    rv_uncore_wb dut (.*);

    always #20 i_clk = ~i_clk;

    function automatic logic next_random_bit();
        logic bit_out;
        bit_out = lfsr_q[0];
        lfsr_q  = lfsr_q >> 1;
        if (bit_out)
            lfsr_q = lfsr_q ^ 16'hb400;                 // galois taps 16,14,13,11.
        return bit_out;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            abort_run($sformatf("error: time %0t, %s = %h, expected %h", $time, name, got, exp));
    endtask

    // ----------------------------------------
    // wishbone memory model
    // ----------------------------------------
    always @(posedge i_clk)
    begin
        s_rst = i_rst;
        s_cyc = o_wb_cyc;
        s_stb = o_wb_stb;
        s_we  = o_wb_we;
        s_adr = o_wb_adr;
        s_dat = o_wb_dat;
        s_sel = o_wb_sel;
    end

    always @(negedge i_clk)
    begin
        if (s_rst)
        begin
            i_wb_ack = 1'b0;
            busy     = 1'b0;
        end
        else if (i_wb_ack)
        begin
            i_wb_ack = 1'b0;                            // single cycle ack.
        end
        else if (s_cyc && s_stb)
        begin
            if (!busy)
            begin
                busy         = 1'b1;
                wait_left[1] = next_random_bit();
                wait_left[0] = next_random_bit();
            end
            if (wait_left == 2'd0)
            begin
                busy = 1'b0;
                if (s_we)
                begin
                    for (int b = 0; b < 4; b++)
                        if (s_sel[b])
                            mem[s_adr[9:2]][8*b +: 8] = s_dat[8*b +: 8];
                end
                i_wb_dat = mem[s_adr[9:2]];
                i_wb_ack = 1'b1;
            end
            else
                wait_left = wait_left - 2'd1;
        end
    end

    always @(negedge i_clk)
    begin
        if (dut.u_assert.fail_count != 0)
            abort_run("a bound assertion failed");
    end

    // ----------------------------------------
    // core side drivers
    // ----------------------------------------
    task automatic check_owner(input logic data_port);
        compare_value("o_wb_cyc", 32'(o_wb_cyc), 32'd1);
        compare_value("o_wb_stb", 32'(o_wb_stb), 32'd1);
        if (data_port)
        begin
            compare_value("o_wb_adr", o_wb_adr, i_data_addr);
            compare_value("o_wb_sel", 32'(o_wb_sel), 32'(i_data_sel));
            compare_value("o_wb_we", 32'(o_wb_we), 32'(i_data_write));
            if (i_data_write)
                compare_value("o_wb_dat", o_wb_dat, i_data_wdata);
            compare_value("o_instr_ack", 32'(o_instr_ack), 32'd0);
        end
        else
        begin
            compare_value("o_wb_adr", o_wb_adr, i_instr_addr);
            compare_value("o_wb_sel", 32'(o_wb_sel), 32'hf);
            compare_value("o_wb_we", 32'(o_wb_we), 32'd0);
        end
    endtask

    task automatic wait_port_ack(input logic data_port, output word_t rdata);
        int n;
        n = 0;
        @(posedge i_clk);
        check_owner(data_port);
        while (!(data_port ? o_data_ack : o_instr_ack))
        begin
            n++;
            if (n > ACK_TIMEOUT)
                abort_run("timeout while waiting for a bus ack");
            @(posedge i_clk);
            check_owner(data_port);
        end
        rdata = data_port ? o_data_rdata : o_instr_data;
    endtask

    task automatic fetch_word(input addr_t addr, input word_t exp);
        word_t got;
        i_instr_req  = 1'b1;
        i_instr_addr = addr;
        wait_port_ack(1'b0, got);
        compare_value("o_instr_data", got, exp);
        @(negedge i_clk);
        i_instr_req = 1'b0;
    endtask

    task automatic data_access(input logic wr, input addr_t addr, input word_t wdata,
                               input sel_t sel, input word_t exp);
        word_t got;
        i_data_req   = 1'b1;
        i_data_write = wr;
        i_data_addr  = addr;
        i_data_wdata = wdata;
        i_data_sel   = sel;
        wait_port_ack(1'b1, got);
        if (!wr)
            compare_value("o_data_rdata", got, exp);
        @(negedge i_clk);
        i_data_req = 1'b0;
    endtask

    task automatic fetch_and_load(input addr_t f_addr, input addr_t l_addr,
                                  input word_t f_exp, input word_t l_exp);
        word_t got;
        i_instr_req  = 1'b1;
        i_instr_addr = f_addr;
        i_data_req   = 1'b1;
        i_data_write = 1'b0;
        i_data_addr  = l_addr;
        i_data_sel   = 4'hf;
        wait_port_ack(1'b1, got);                       // load goes first.
        compare_value("o_data_rdata", got, l_exp);
        @(negedge i_clk);
        i_data_req = 1'b0;
        wait_port_ack(1'b0, got);
        compare_value("o_instr_data", got, f_exp);
        @(negedge i_clk);
        i_instr_req = 1'b0;
    endtask

    task automatic csr_modify(input byte kind, input csr_idx_t idx, input word_t data);
        i_csr_idx   = idx;
        i_csr_wdata = data;
        i_csr_write = (kind == "w");
        i_csr_set   = (kind == "s");
        i_csr_clear = (kind == "c");
        @(negedge i_clk);
        i_csr_write = 1'b0;
        i_csr_set   = 1'b0;
        i_csr_clear = 1'b0;
    endtask

    task automatic csr_read_check(input csr_idx_t idx, input word_t exp, input logic exp_ill);
        i_csr_idx  = idx;
        i_csr_read = 1'b1;
        @(negedge i_clk);
        i_csr_read = 1'b0;
        compare_value("o_csr_valid", 32'(o_csr_valid), 32'd1);
        compare_value("o_csr_illegal", 32'(o_csr_illegal), 32'(exp_ill));
        compare_value("o_csr_rdata", o_csr_rdata, exp);
        compare_value("o_wb_cyc", 32'(o_wb_cyc), 32'd0);     // bus idle here.
        compare_value("o_wb_stb", 32'(o_wb_stb), 32'd0);
    endtask

    task automatic pulse_instret(input int count);
        for (int k = 0; k < count; k++)
        begin
            i_instret = 1'b1;
            @(negedge i_clk);
            i_instret = 1'b0;
            @(negedge i_clk);
        end
    endtask

    initial
    begin
        for (int i = 0; i < 256; i++)
            mem[i] = ~word_t'(i * 4);                   // inverted address.
        lfsr_q       = 16'd91;
        i_clk        = 1'b0;
        i_rst        = 1'b1;
        i_instr_req  = 1'b0;
        i_instr_addr = '0;
        i_data_req   = 1'b0;
        i_data_write = 1'b0;
        i_data_addr  = '0;
        i_data_wdata = '0;
        i_data_sel   = '0;
        i_csr_idx    = '0;
        i_csr_wdata  = '0;
        i_csr_write  = 1'b0;
        i_csr_set    = 1'b0;
        i_csr_clear  = 1'b0;
        i_csr_read   = 1'b0;
        i_instret    = 1'b0;
        i_wb_dat     = '0;
        i_wb_ack     = 1'b0;
        repeat (16) @(negedge i_clk);
        i_rst = 1'b0;

        fd = $fopen("test/rv_uncore_vectors.txt", "r");
        if (fd == 0)
            abort_run("cannot open the vector file test/rv_uncore_vectors.txt");
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if ((line.len() < 2) || (line[0] == "#"))
                continue;
            nfields = $sscanf(line, "%c %h %h %h %h", op, f_a, f_b, f_c, f_d);
            if (nfields != 5)
                abort_run({"malformed line in the vector file: ", line});
            case (op)
                "F":     fetch_word(f_a, f_b);
                "L":     data_access(1'b0, f_a, '0, f_c[3:0], f_b);
                "S":     data_access(1'b1, f_a, f_b, f_c[3:0], '0);
                "P":     fetch_and_load(f_a, f_b, f_c, f_d);
                "w":     csr_modify(op, f_a[11:0], f_b);
                "s":     csr_modify(op, f_a[11:0], f_b);
                "c":     csr_modify(op, f_a[11:0], f_b);
                "r":     csr_read_check(f_a[11:0], f_b, f_c[0]);
                "i":     pulse_instret(int'(f_a));
                default: abort_run({"unknown operation in the vector file: ", line});
            endcase
        end
        $fclose(fd);

        repeat (2) @(negedge i_clk);
        if (dut.u_assert.fail_count == 0)
        begin
            $display("Testbench passed");
            $finish;
        end
        else
            abort_run("the bound assertions reported a failure");
    end

endmodule

`default_nettype wire

//--- test/rv_uncore_assert.sv
`default_nettype none

module rv_uncore_assert
(
    input   wire                        i_clk,
    input   wire                        i_rst,
    input   wire                        i_data_req,
    input   wire                        i_wb_ack,
    input   wire                        o_wb_cyc,
    input   wire                        o_instr_ack,
    input   wire                        o_data_ack,
    input   wire                        i_csr_read,
    input   wire                        o_csr_valid
);

    int fail_count = 0;

    a_one_ack: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_wb_cyc && i_wb_ack) |-> (o_instr_ack != o_data_ack))
    else
    begin
        $error("slave ack reached both ports or neither");
        fail_count++;
    end

    // data port owns the bus.
    a_data_first: assert property (@(posedge i_clk) disable iff (i_rst)
        i_data_req |-> !o_instr_ack)
    else
    begin
        $error("fetch acked while a data request is pending");
        fail_count++;
    end

    a_csr_valid: assert property (@(posedge i_clk) disable iff (i_rst)
        o_csr_valid == $past(i_csr_read))
    else
    begin
        $error("csr valid not one cycle after the read strobe");
        fail_count++;
    end

endmodule

bind rv_uncore_wb rv_uncore_assert u_assert
(
    .i_clk                              (i_clk),
    .i_rst                              (i_rst),
    .i_data_req                         (i_data_req),
    .i_wb_ack                           (i_wb_ack),
    .o_wb_cyc                           (o_wb_cyc),
    .o_instr_ack                        (o_instr_ack),
    .o_data_ack                         (o_data_ack),
    .i_csr_read                         (i_csr_read),
    .o_csr_valid                        (o_csr_valid)
);

`default_nettype wire

//--- source/rv_uncore_wb.sv
`default_nettype none

module rv_uncore_wb
(
    input   wire                        i_clk,
    input   wire                        i_rst,
    //
    input   wire                        i_instr_req,
    input   wire rv_pkg::addr_t         i_instr_addr,
    output  wire                        o_instr_ack,
    output  wire rv_pkg::word_t         o_instr_data,
    //
    input   wire                        i_data_req,
    input   wire                        i_data_write,
    input   wire rv_pkg::addr_t         i_data_addr,
    input   wire rv_pkg::word_t         i_data_wdata,
    input   wire rv_pkg::sel_t          i_data_sel,
    output  wire                        o_data_ack,
    output  wire rv_pkg::word_t         o_data_rdata,
    //
    input   wire rv_pkg::csr_idx_t      i_csr_idx,
    input   wire rv_pkg::word_t         i_csr_wdata,
    input   wire                        i_csr_write,
    input   wire                        i_csr_set,
    input   wire                        i_csr_clear,
    input   wire                        i_csr_read,
    output  wire rv_pkg::word_t         o_csr_rdata,
    output  wire                        o_csr_valid,
    output  wire                        o_csr_illegal,
    input   wire                        i_instret,
    //
    output  wire rv_pkg::addr_t         o_wb_adr,
    output  wire rv_pkg::word_t         o_wb_dat,
    input   wire rv_pkg::word_t         i_wb_dat,
    output  wire                        o_wb_we,
    output  wire rv_pkg::sel_t          o_wb_sel,
    output  wire                        o_wb_stb,
    output  wire                        o_wb_cyc,
    input   wire                        i_wb_ack
);

    import rv_pkg::*;

    logic [NUM_HPM-1:0] evt_we;
    ev_code_t           evt_wdata;
    ev_code_t           evt_sel [NUM_HPM];
    logic [NUM_HPM-1:0] hpm_inc;

    rv_bus_ev_if u_bus_ev ();
    rv_csr_if    u_csr_if ();

    rv_wb_arbiter u_arbiter
    (
        .i_clk                          (i_clk),
        .i_rst                          (i_rst),
        .i_instr_req                    (i_instr_req),
        .i_instr_addr                   (i_instr_addr),
        .o_instr_ack                    (o_instr_ack),
        .o_instr_data                   (o_instr_data),
        .i_data_req                     (i_data_req),
        .i_data_write                   (i_data_write),
        .i_data_addr                    (i_data_addr),
        .i_data_wdata                   (i_data_wdata),
        .i_data_sel                     (i_data_sel),
        .o_data_ack                     (o_data_ack),
        .o_data_rdata                   (o_data_rdata),
        .o_wb_adr                       (o_wb_adr),
        .o_wb_dat                       (o_wb_dat),
        .i_wb_dat                       (i_wb_dat),
        .o_wb_we                        (o_wb_we),
        .o_wb_sel                       (o_wb_sel),
        .o_wb_stb                       (o_wb_stb),
        .o_wb_cyc                       (o_wb_cyc),
        .i_wb_ack                       (i_wb_ack),
        .ev                             (u_bus_ev)
    );

    rv_hpm_event_sel u_event_sel
    (
        .i_clk                          (i_clk),
        .i_rst                          (i_rst),
        .i_instret                      (i_instret),
        .ev                             (u_bus_ev),
        .i_evt_we                       (evt_we),
        .i_evt_wdata                    (evt_wdata),
        .o_evt_sel                      (evt_sel),
        .o_inc                          (hpm_inc)
    );

    rv_csr_file u_csr_file
    (
        .i_clk                          (i_clk),
        .i_rst                          (i_rst),
        .i_csr_idx                      (i_csr_idx),
        .i_csr_wdata                    (i_csr_wdata),
        .i_csr_write                    (i_csr_write),
        .i_csr_set                      (i_csr_set),
        .i_csr_clear                    (i_csr_clear),
        .i_csr_read                     (i_csr_read),
        .o_csr_rdata                    (o_csr_rdata),
        .o_csr_valid                    (o_csr_valid),
        .o_csr_illegal                  (o_csr_illegal),
        .i_instret                      (i_instret),
        .o_evt_we                       (evt_we),
        .o_evt_wdata                    (evt_wdata),
        .i_evt_sel                      (evt_sel),
        .i_hpm_inc                      (hpm_inc),
        .ctl                            (u_csr_if),
        .cnt                            (u_csr_if)
    );

endmodule

`default_nettype wire

//--- csr/rv_csr_file.sv
`default_nettype none

module rv_csr_file
(
    input   wire                        i_clk,
    input   wire                        i_rst,
    input   wire rv_pkg::csr_idx_t      i_csr_idx,
    input   wire rv_pkg::word_t         i_csr_wdata,
    input   wire                        i_csr_write,
    input   wire                        i_csr_set,
    input   wire                        i_csr_clear,
    input   wire                        i_csr_read,
    output  rv_pkg::word_t              o_csr_rdata,
    output  logic                       o_csr_valid,
    output  logic                       o_csr_illegal,
    input   wire                        i_instret,
    output  logic [rv_pkg::NUM_HPM-1:0] o_evt_we,
    output  rv_pkg::ev_code_t           o_evt_wdata,
    input   wire rv_pkg::ev_code_t      i_evt_sel [rv_pkg::NUM_HPM],
    input   wire [rv_pkg::NUM_HPM-1:0]  i_hpm_inc,
    rv_csr_if.ctrl                      ctl,
    rv_csr_if.cnt                       cnt
);

    import rv_pkg::*;

    word_t              mscratch;
    word_t              mcountinhibit;
    word_t              old_val;
    word_t              new_val;
    logic               known;
    logic               csr_we;
    logic [NUM_CNT-1:0] lo_hit;
    logic [NUM_CNT-1:0] hi_hit;
    logic [NUM_CNT-1:0] cnt_inc;
    logic [NUM_HPM-1:0] evt_hit;

    // counter index to csr address.
    function automatic csr_idx_t cnt_lo(input int c);
        if (c == 0)
            return CSR_MCYCLE;
        if (c == 1)
            return CSR_MINSTRET;
        return CSR_MHPMCOUNTER3 + 12'(c - 2);
    endfunction

    function automatic csr_idx_t cnt_hi(input int c);
        if (c == 0)
            return CSR_MCYCLEH;
        if (c == 1)
            return CSR_MINSTRETH;
        return CSR_MHPMCOUNTER3H + 12'(c - 2);
    endfunction

    // ----------------------------------------
    // decode and read mux
    // ----------------------------------------
    always_comb
    begin
        known   = 1'b0;
        old_val = '0;
        lo_hit  = '0;
        hi_hit  = '0;
        evt_hit = '0;
        if (i_csr_idx == CSR_MSCRATCH)
        begin
            known   = 1'b1;
            old_val = mscratch;
        end
        if (i_csr_idx == CSR_MCOUNTINHIBIT)
        begin
            known   = 1'b1;
            old_val = mcountinhibit;
        end
        for (int c = 0; c < NUM_CNT; c++)
        begin
            if (i_csr_idx == cnt_lo(c))
            begin
                known     = 1'b1;
                lo_hit[c] = 1'b1;
                old_val   = ctl.value[c][31:0];
            end
            if (i_csr_idx == cnt_hi(c))
            begin
                known     = 1'b1;
                hi_hit[c] = 1'b1;
                old_val   = ctl.value[c][63:32];
            end
        end
        for (int j = 0; j < NUM_HPM; j++)
        begin
            if (i_csr_idx == CSR_MHPMEVENT3 + 12'(j))
            begin
                known      = 1'b1;
                evt_hit[j] = 1'b1;
                old_val    = {29'd0, i_evt_sel[j]};
            end
        end
    end

    // read-modify-write on the old value.
    always_comb
    begin
        new_val = old_val;
        if (i_csr_write)
            new_val = i_csr_wdata;
        else if (i_csr_set)
            new_val = old_val | i_csr_wdata;
        else if (i_csr_clear)
            new_val = old_val & (~i_csr_wdata);
    end

    assign csr_we = known & (i_csr_write | i_csr_set | i_csr_clear);

    // ----------------------------------------
    // counter control
    // ----------------------------------------
    assign ctl.wr_lo = lo_hit & {NUM_CNT{csr_we}};
    assign ctl.wr_hi = hi_hit & {NUM_CNT{csr_we}};
    assign ctl.wdata = new_val;

    always_comb
    begin
        ctl.inhibit[0] = mcountinhibit[0];              // cy.
        ctl.inhibit[1] = mcountinhibit[2];              // ir.
        for (int j = 0; j < NUM_HPM; j++)
            ctl.inhibit[2 + j] = mcountinhibit[HPM_BASE + j];
    end

    assign cnt_inc     = {i_hpm_inc, i_instret, 1'b1};
    assign o_evt_we    = evt_hit & {NUM_HPM{csr_we}};
    assign o_evt_wdata = ev_code_t'(new_val[2:0]);

    generate
        for (genvar g = 0; g < NUM_CNT; g++)
        begin : g_cnt
            rv_hpm_counter u_cnt
            (
                .i_clk                  (i_clk),
                .i_rst                  (i_rst),
                .i_inc                  (cnt_inc[g]),
                .i_inhibit              (cnt.inhibit[g]),
                .i_wr_lo                (cnt.wr_lo[g]),
                .i_wr_hi                (cnt.wr_hi[g]),
                .i_wdata                (cnt.wdata),
                .o_value                (cnt.value[g])
            );
        end
    endgenerate

    // ----------------------------------------
    // fixed csrs and read response
    // ----------------------------------------
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            mscratch      <= '0;
            mcountinhibit <= '0;
            o_csr_valid   <= 1'b0;
            o_csr_illegal <= 1'b0;
        end
        else
        begin
            if (csr_we && (i_csr_idx == CSR_MSCRATCH))
                mscratch <= new_val;
            if (csr_we && (i_csr_idx == CSR_MCOUNTINHIBIT))
                mcountinhibit <= new_val & MCOUNTINHIBIT_MASK;
            o_csr_valid   <= i_csr_read;
            o_csr_illegal <= i_csr_read & (!known);
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_csr_read)
            o_csr_rdata <= old_val;                     // zero when unknown.
    end

endmodule

`default_nettype wire

//--- csr/rv_hpm_counter.sv
`default_nettype none

module rv_hpm_counter
(
    input   wire                        i_clk,
    input   wire                        i_rst,
    input   wire                        i_inc,
    input   wire                        i_inhibit,
    input   wire                        i_wr_lo,
    input   wire                        i_wr_hi,
    input   wire rv_pkg::word_t         i_wdata,
    output  rv_pkg::counter_t           o_value
);

    import rv_pkg::*;

    counter_t value_q;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            value_q <= '0;
        end
        else if (i_wr_lo)
        begin
            value_q <= {value_q[63:32], i_wdata};       // write beats increment.
        end
        else if (i_wr_hi)
        begin
            value_q <= {i_wdata, value_q[31:0]};
        end
        else if (i_inc && !i_inhibit)
        begin
            value_q <= value_q + 64'd1;
        end
    end

    assign o_value = value_q;

endmodule

`default_nettype wire

//--- csr/rv_hpm_event_sel.sv
`default_nettype none

module rv_hpm_event_sel
(
    input   wire                        i_clk,
    input   wire                        i_rst,
    input   wire                        i_instret,
    rv_bus_ev_if.dst                    ev,
    input   wire [rv_pkg::NUM_HPM-1:0]  i_evt_we,
    input   wire rv_pkg::ev_code_t      i_evt_wdata,
    output  rv_pkg::ev_code_t           o_evt_sel [rv_pkg::NUM_HPM],
    output  logic [rv_pkg::NUM_HPM-1:0] o_inc
);

    import rv_pkg::*;

    ev_code_t evt_q [NUM_HPM];

    // mhpmevent3..6.
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            for (int j = 0; j < NUM_HPM; j++)
                evt_q[j] <= EV_NONE;
        end
        else
        begin
            for (int j = 0; j < NUM_HPM; j++)
            begin
                if (i_evt_we[j])
                    evt_q[j] <= i_evt_wdata;
            end
        end
    end

    always_comb
    begin
        for (int j = 0; j < NUM_HPM; j++)
        begin
            case (evt_q[j])
                EV_FETCH:   o_inc[j] = ev.fetch_ack;
                EV_LOAD:    o_inc[j] = ev.load_ack;
                EV_STORE:   o_inc[j] = ev.store_ack;
                EV_STALL:   o_inc[j] = ev.stall;
                EV_INSTRET: o_inc[j] = i_instret;
                default:    o_inc[j] = 1'b0;        // none or unknown code.
            endcase
        end
    end

    assign o_evt_sel = evt_q;

endmodule

`default_nettype wire

//--- source/rv_wb_arbiter.sv
`default_nettype none

module rv_wb_arbiter
(
    input   wire                        i_clk,
    input   wire                        i_rst,
    //
    input   wire                        i_instr_req,
    input   wire rv_pkg::addr_t         i_instr_addr,
    output  logic                       o_instr_ack,
    output  rv_pkg::word_t              o_instr_data,
    //
    input   wire                        i_data_req,
    input   wire                        i_data_write,
    input   wire rv_pkg::addr_t         i_data_addr,
    input   wire rv_pkg::word_t         i_data_wdata,
    input   wire rv_pkg::sel_t          i_data_sel,
    output  logic                       o_data_ack,
    output  rv_pkg::word_t              o_data_rdata,
    //
    output  rv_pkg::addr_t              o_wb_adr,
    output  rv_pkg::word_t              o_wb_dat,
    input   wire rv_pkg::word_t         i_wb_dat,
    output  logic                       o_wb_we,
    output  rv_pkg::sel_t               o_wb_sel,
    output  logic                       o_wb_stb,
    output  logic                       o_wb_cyc,
    input   wire                        i_wb_ack,
    //
    rv_bus_ev_if.src                    ev
);

    logic bus_req;
    logic stall_q;

    assign bus_req = i_instr_req | i_data_req;

    // ----------------------------------------
    // wishbone master, data port first
    // ----------------------------------------
    assign o_wb_cyc = bus_req;
    assign o_wb_stb = bus_req;
    assign o_wb_adr = i_data_req ? i_data_addr : i_instr_addr;
    assign o_wb_dat = i_data_wdata;
    assign o_wb_we  = i_data_req & i_data_write;        // fetches never write.
    assign o_wb_sel = i_data_req ? i_data_sel : '1;

    assign o_data_ack   = i_wb_ack & i_data_req;
    assign o_instr_ack  = i_wb_ack & i_instr_req & (!i_data_req);
    assign o_instr_data = i_wb_dat;
    assign o_data_rdata = i_wb_dat;

    // ----------------------------------------
    // bus events
    // ----------------------------------------
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            stall_q <= 1'b0;
        else
            stall_q <= bus_req & (!i_wb_ack);           // waiting on the slave.
    end

    assign ev.fetch_ack = o_instr_ack;
    assign ev.load_ack  = o_data_ack & (!i_data_write);
    assign ev.store_ack = o_data_ack & i_data_write;
    assign ev.stall     = stall_q;

endmodule

`default_nettype wire

//--- common/rv_bus_ev_if.sv
`default_nettype none

interface rv_bus_ev_if;

    logic fetch_ack;
    logic load_ack;
    logic store_ack;
    logic stall;                                        // one cycle late.

    modport src
    (
        output fetch_ack, load_ack, store_ack, stall
    );

    modport dst
    (
        input  fetch_ack, load_ack, store_ack, stall
    );

endinterface

`default_nettype wire

//--- common/rv_csr_if.sv
`default_nettype none

interface rv_csr_if;

    import rv_pkg::*;

    logic [NUM_CNT-1:0] wr_lo;                          // write low half.
    logic [NUM_CNT-1:0] wr_hi;                          // write high half.
    logic [NUM_CNT-1:0] inhibit;
    word_t              wdata;
    counter_t           value [NUM_CNT];

    modport ctrl
    (
        output wr_lo, wr_hi, inhibit, wdata,
        input  value
    );

    modport cnt
    (
        input  wr_lo, wr_hi, inhibit, wdata,
        output value
    );

endinterface

`default_nettype wire

//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // ----------------------------------------
    // vector types
    // ----------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  sel_t;
    typedef logic [11:0] csr_idx_t;
    typedef logic [63:0] counter_t;

    // ----------------------------------------
    // counters
    // ----------------------------------------
    localparam int NUM_HPM  = 4;
    localparam int HPM_BASE = 3;                        // mhpmcounter3 is the first.
    localparam int NUM_CNT  = NUM_HPM + 2;              // mcycle, minstret, then hpm.

    // writable mcountinhibit bits: cy, ir, hpm3..hpm6.
    localparam word_t MCOUNTINHIBIT_MASK = 32'h0000_007d;

    // ----------------------------------------
    // csr addresses
    // ----------------------------------------
    localparam csr_idx_t CSR_MSCRATCH      = 12'h340;
    localparam csr_idx_t CSR_MCOUNTINHIBIT = 12'h320;
    localparam csr_idx_t CSR_MHPMEVENT3    = 12'h323;
    localparam csr_idx_t CSR_MCYCLE        = 12'hb00;
    localparam csr_idx_t CSR_MINSTRET      = 12'hb02;
    localparam csr_idx_t CSR_MHPMCOUNTER3  = 12'hb03;
    localparam csr_idx_t CSR_MCYCLEH       = 12'hb80;
    localparam csr_idx_t CSR_MINSTRETH     = 12'hb82;
    localparam csr_idx_t CSR_MHPMCOUNTER3H = 12'hb83;

    // event selector codes.
    typedef enum logic [2:0]
    {
        EV_NONE    = 3'd0,
        EV_FETCH   = 3'd1,
        EV_LOAD    = 3'd2,
        EV_STORE   = 3'd3,
        EV_STALL   = 3'd4,
        EV_INSTRET = 3'd5
    } ev_code_t;

endpackage

`default_nettype wire
